// File: all.f
src/fetch_pkg.sv
src/cache_ram.sv
src/fetch_pc.sv
src/instr_cache.sv
src/fetch_top.sv
sim/tb_bus_memory.sv
sim/tb_fetch.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       = tb_fetch
FILELIST  = all.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

	localparam int INDEX_BITS = 6;
	localparam int LINES = 2 ** INDEX_BITS;
	localparam int ROWS = 7;
	localparam int RESET_CYCLES = 4;
	localparam logic [31:0] MEMORY_KEY = 32'hA5A5_0000;

	typedef struct packed {
		logic [31:0] target;
		logic [15:0] count;
		logic        stall_pattern;
		logic [15:0] requests;
	} row_t;

	logic              clock;
	logic              reset;
	logic              stall;
	logic              redirect;
	logic [31:0]       redirect_pc;
	wire               bus_ready;
	wire  [31:0]       bus_rdata;
	wire               bus_request;
	wire  [31:0]       bus_address;
	fetch_pkg::fetch_t fetch;
	int                transfers;

	row_t rows [ROWS];
	int   errors = 0;
	int   checks = 0;
	int   cycle_count = 0;
	int   cycle_limit;
	logic quiet_stall = 1'b0;

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	fetch_top #(
		.INDEX_BITS (INDEX_BITS)
	) uut (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_stall       (stall),
		.i_redirect    (redirect),
		.i_redirect_pc (redirect_pc),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata),
		.o_bus_request (bus_request),
		.o_bus_address (bus_address),
		.o_fetch       (fetch)
	);

	tb_bus_memory u_memory (
		.i_clock     (clock),
		.i_reset     (reset),
		.i_request   (bus_request),
		.i_address   (bus_address),
		.o_ready     (bus_ready),
		.o_rdata     (bus_rdata),
		.o_transfers (transfers)
	);

	// A stalled edge without a bus answer must not deliver on the next one.
	always @(posedge clock) begin
		quiet_stall <= stall && !bus_ready;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic load_table();
		// Fresh range, then the same range again from the cache.
		rows[0] = '{target: 32'h0000_0100, count: 16'd16, stall_pattern: 1'b0, requests: 16'd16};
		rows[1] = '{target: 32'h0000_0100, count: 16'd16, stall_pattern: 1'b0, requests: 16'd0};
		// Same indices with other upper address bits.
		rows[2] = '{target: 32'h0000_1100, count: 16'd8, stall_pattern: 1'b0, requests: 16'd8};
		rows[3] = '{target: 32'h0000_0100, count: 16'd8, stall_pattern: 1'b0, requests: 16'd8};
		// Stalls on misses, then on hits.
		rows[4] = '{target: 32'h0000_0240, count: 16'd20, stall_pattern: 1'b1, requests: 16'd20};
		rows[5] = '{target: 32'h0000_0240, count: 16'd20, stall_pattern: 1'b1, requests: 16'd0};
		rows[6] = '{target: 32'h0000_0100, count: 16'd16, stall_pattern: 1'b0, requests: 16'd0};
	endtask

	task automatic check_fetch(input logic [31:0] expected_pc);
		checks += 2;
		if (fetch.pc !== expected_pc) begin
			errors++;
			$display("Error at %0t: o_fetch.pc = %h, expected %h", $time, fetch.pc, expected_pc);
		end
		if (fetch.instr !== (expected_pc ^ MEMORY_KEY)) begin
			errors++;
			$display("Error at %0t: o_fetch.instr = %h, expected %h",
				$time, fetch.instr, expected_pc ^ MEMORY_KEY);
		end
	endtask

	task automatic check_quiet();
		checks++;
		if (quiet_stall && fetch.valid) begin
			errors++;
			$display("Error at %0t: o_fetch.valid = 1, expected 0 under stall", $time);
		end
	endtask

	// Reset and the clearing walk, with no bus traffic and no delivery.
	task automatic reset_and_check_clear();
		stall = 1'b0;
		reset = 1'b1;
		for (int i = 0; i < RESET_CYCLES + LINES; i++) begin
			@(negedge clock);
			checks += 2;
			if (bus_request !== 1'b0) begin
				errors++;
				$display("Error at %0t: o_bus_request = %b, expected 0", $time, bus_request);
			end
			if (fetch.valid !== 1'b0) begin
				errors++;
				$display("Error at %0t: o_fetch.valid = %b, expected 0", $time, fetch.valid);
			end
			if (i == RESET_CYCLES - 1) begin
				reset = 1'b0;
			end
		end
	endtask

	// Starts and ends on a falling edge, and ends with the stall high.
	task automatic apply_row(input int r);
		row_t        row;
		int          start_transfers;
		int          collected;
		int          waited;
		logic [31:0] expected_pc;

		row = rows[r];
		start_transfers = transfers;
		redirect = 1'b1;
		redirect_pc = row.target;
		@(negedge clock);
		redirect = 1'b0;
		expected_pc = row.target;
		collected = 0;
		waited = 0;
		stall = 1'b0;
		while (collected < int'(row.count)) begin
			@(negedge clock);
			waited++;
			check_quiet();
			if (fetch.valid) begin
				check_fetch(expected_pc);
				expected_pc = expected_pc + 32'd4;
				collected++;
			end
			// A miss always fetches the next pc still to be delivered.
			if (bus_request) begin
				checks++;
				if (bus_address !== expected_pc) begin
					errors++;
					$display("Error at %0t: o_bus_address = %h, expected %h",
						$time, bus_address, expected_pc);
				end
			end
			if (collected == int'(row.count)) begin
				stall = 1'b1;
			end else begin
				stall = row.stall_pattern && (waited % 5 >= 3);
			end
		end
		repeat (3) begin
			@(negedge clock);
			checks++;
			if (fetch.valid) begin
				errors++;
				$display("Error at %0t: o_fetch.valid = 1, expected 0 after row %0d", $time, r);
			end
		end
		checks++;
		if (transfers - start_transfers != int'(row.requests)) begin
			errors++;
			$display("Error at %0t: bus requests of row %0d = %0d, expected %0d",
				$time, r, transfers - start_transfers, row.requests);
		end
	endtask

	initial begin
		int total;

		reset = 1'b1;
		stall = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		load_table();
		total = int'(rows[0].count);
		for (int r = 0; r < ROWS; r++) begin
			total += int'(rows[r].count);
		end
		cycle_limit = 64 + LINES + 8 * total;

		reset_and_check_clear();
		for (int r = 0; r < ROWS; r++) begin
			apply_row(r);
		end

		// The range cached by the first row must miss again.
		reset_and_check_clear();
		apply_row(0);

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/tb_bus_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_memory (
	input  wire         i_clock,
	input  wire         i_reset,
	input  wire         i_request,
	input  wire  [31:0] i_address,
	output logic        o_ready,
	output logic [31:0] o_rdata,
	output int          o_transfers
);

	integer      seed;
	int          remaining;
	logic        busy;
	logic        fire;
	logic [31:0] fire_address;

	initial begin
		seed = 60;
		remaining = 0;
		busy = 1'b0;
		fire = 1'b0;
		fire_address = '0;
		o_ready = 1'b0;
		o_rdata = '0;
		o_transfers = 0;
	end

	// Request is taken at the rising edge and answered 1 to 4 edges later.
	always @(posedge i_clock) begin
		fire <= 1'b0;
		if (i_reset) begin
			busy = 1'b0;
		end else if (i_request && !o_ready) begin
			if (!busy) begin
				busy = 1'b1;
				remaining = 1 + ($unsigned($random(seed)) % 4);
			end
			remaining = remaining - 1;
			if (remaining == 0) begin
				busy = 1'b0;
				fire <= 1'b1;
				fire_address <= i_address;
			end
		end
	end

	// Memory content is the address with its upper half scrambled.
	always @(negedge i_clock) begin
		o_ready <= fire;
		if (fire) begin
			o_rdata <= fire_address ^ 32'hA5A5_0000;
			o_transfers <= o_transfers + 1;
		end
	end

endmodule

`default_nettype wire

// File: src/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
	parameter int INDEX_BITS = 6
) (
	input  wire               i_clock,
	input  wire               i_reset,
	input  wire               i_stall,
	input  wire               i_redirect,
	input  wire [31:0]        i_redirect_pc,
	input  wire               i_bus_ready,
	input  wire [31:0]        i_bus_rdata,
	output logic              o_bus_request,
	output logic [31:0]       o_bus_address,
	output fetch_pkg::fetch_t o_fetch
);

	logic [31:0]            pc;
	logic                   ready;
	logic [31:0]            instr;
	logic                   ram_write;
	logic [INDEX_BITS-1:0]  ram_index;
	fetch_pkg::cache_line_t ram_wline;
	fetch_pkg::cache_line_t ram_rline;

	fetch_pc u_fetch_pc (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_redirect    (i_redirect),
		.i_redirect_pc (i_redirect_pc),
		.i_ready       (ready),
		.i_instr       (instr),
		.o_pc          (pc),
		.o_fetch       (o_fetch)
	);

	instr_cache #(
		.INDEX_BITS (INDEX_BITS)
	) u_instr_cache (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_stall       (i_stall),
		.i_pc          (pc),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata),
		.i_line        (ram_rline),
		.o_ready       (ready),
		.o_instr       (instr),
		.o_bus_request (o_bus_request),
		.o_bus_address (o_bus_address),
		.o_ram_write   (ram_write),
		.o_ram_index   (ram_index),
		.o_ram_line    (ram_wline)
	);

	cache_ram #(
		.INDEX_BITS (INDEX_BITS)
	) u_cache_ram (
		.i_clock (i_clock),
		.i_write (ram_write),
		.i_index (ram_index),
		.i_line  (ram_wline),
		.o_line  (ram_rline)
	);

endmodule

`default_nettype wire

// File: src/instr_cache.sv
`timescale 1ns/1ps
`default_nettype none

module instr_cache #(
	parameter int INDEX_BITS = 6
) (
	input  wire                         i_clock,
	input  wire                         i_reset,
	input  wire                         i_stall,
	input  wire [31:0]                  i_pc,
	input  wire                         i_bus_ready,
	input  wire [31:0]                  i_bus_rdata,
	input  wire fetch_pkg::cache_line_t i_line,
	output logic                        o_ready,
	output logic [31:0]                 o_instr,
	output logic                        o_bus_request,
	output logic [31:0]                 o_bus_address,
	output logic                        o_ram_write,
	output logic [INDEX_BITS-1:0]       o_ram_index,
	output fetch_pkg::cache_line_t      o_ram_line
);

	fetch_pkg::cache_state_e state;
	fetch_pkg::cache_state_e next_state;

	logic [INDEX_BITS-1:0] clear_index;
	logic [INDEX_BITS-1:0] next_clear;
	logic [INDEX_BITS-1:0] read_index;
	logic [31:0]           miss_pc;
	logic [31:0]           pc_next;
	logic [INDEX_BITS-1:0] pc_index;
	logic [INDEX_BITS-1:0] next_index;
	logic [INDEX_BITS-1:0] miss_index;

	assign pc_next = i_pc + 32'd4;
	assign pc_index = i_pc[INDEX_BITS+1:2];
	assign next_index = pc_next[INDEX_BITS+1:2];
	assign miss_index = miss_pc[INDEX_BITS+1:2];

	// Address is held from the miss until the bus answers.
	assign o_bus_address = (state == fetch_pkg::read_bus) ? miss_pc : i_pc;

	always_comb begin
		next_state = state;
		next_clear = clear_index;
		o_ready = 1'b0;
		o_instr = i_line.instr;
		o_bus_request = 1'b0;
		o_ram_write = 1'b0;
		o_ram_index = pc_index;
		o_ram_line = '{instr: i_bus_rdata, tag: fetch_pkg::make_tag(miss_pc)};

		case (state)
			fetch_pkg::idle: begin
				if (!i_stall) begin
					next_state = fetch_pkg::read_setup;
				end
			end

			fetch_pkg::read_setup: begin
				if (i_stall) begin
					next_state = fetch_pkg::idle;
				end else if (read_index != pc_index) begin
					// Line read for an old pc, read again at the new one.
					next_state = fetch_pkg::read_setup;
				end else if (i_line.tag == fetch_pkg::make_tag(i_pc)) begin
					o_ready = 1'b1;
					o_ram_index = next_index;
				end else begin
					o_bus_request = 1'b1;
					next_state = fetch_pkg::read_bus;
				end
			end

			fetch_pkg::read_bus: begin
				o_bus_request = 1'b1;
				o_ram_index = miss_index;
				if (i_bus_ready) begin
					o_ram_write = 1'b1;
					o_instr = i_bus_rdata;
					// No delivery if the pc moved on while waiting.
					o_ready = (i_pc == miss_pc);
					next_state = fetch_pkg::idle;
				end
			end

			fetch_pkg::initialize: begin
				o_ram_write = 1'b1;
				o_ram_index = clear_index;
				o_ram_line = '0;
				next_clear = clear_index + 1'b1;
				if (clear_index == '1) begin
					next_state = fetch_pkg::idle;
				end
			end

			default: begin
				next_state = fetch_pkg::initialize;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::initialize;
			clear_index <= '0;
		end else begin
			state <= next_state;
			clear_index <= next_clear;
		end
	end

	always_ff @(posedge i_clock) begin
		read_index <= o_ram_index;
		if (state == fetch_pkg::read_setup && o_bus_request) begin
			miss_pc <= i_pc;
		end
	end

	// Clearing runs from reset until the index wraps to zero.
	a_no_request_init: assert property (
		@(posedge i_clock) ($past(i_reset) || clear_index != '0) |-> !o_bus_request
	) else $error("instr_cache: bus request while clearing");

	a_address_stable: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(o_bus_request && !i_bus_ready) |=> (o_bus_request && $stable(o_bus_address))
	) else $error("instr_cache: bus address moved under request");

endmodule

`default_nettype wire

// File: src/fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc (
	input  wire                i_clock,
	input  wire                i_reset,
	input  wire                i_redirect,
	input  wire [31:0]         i_redirect_pc,
	input  wire                i_ready,
	input  wire [31:0]         i_instr,
	output logic [31:0]        o_pc,
	output fetch_pkg::fetch_t  o_fetch
);

	logic [31:0] pc;
	logic        fetch_valid;
	logic [31:0] fetch_pc_q;
	logic [31:0] fetch_instr;

	// A redirect wins over the step and drops the word fetched in that cycle.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc <= fetch_pkg::RESET_PC;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= i_ready && !i_redirect;
			if (i_redirect) begin
				pc <= i_redirect_pc;
			end else if (i_ready) begin
				pc <= pc + 32'd4;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_ready) begin
			fetch_pc_q <= pc;
			fetch_instr <= i_instr;
		end
	end

	assign o_pc = pc;
	assign o_fetch = '{valid: fetch_valid, pc: fetch_pc_q, instr: fetch_instr};

	// Redirect targets and steps keep the pc on a word boundary.
	a_pc_aligned: assert property (
		@(posedge i_clock) disable iff (i_reset) o_pc[1:0] == 2'b00
	) else $error("fetch_pc: unaligned pc %h", o_pc);

endmodule

`default_nettype wire

// File: src/cache_ram.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ram #(
	parameter int INDEX_BITS = 6
) (
	input  wire                    i_clock,
	input  wire                    i_write,
	input  wire [INDEX_BITS-1:0]   i_index,
	input  wire fetch_pkg::cache_line_t i_line,
	output fetch_pkg::cache_line_t o_line
);

	localparam int LINES = 2 ** INDEX_BITS;

	fetch_pkg::cache_line_t mem [LINES];

	// One cycle read latency. A write shows its new line on the output.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_index] <= i_line;
			o_line <= i_line;
		end else begin
			o_line <= mem[i_index];
		end
	end

endmodule

`default_nettype wire

// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// Cache controller states.
	typedef enum logic [1:0] {
		idle       = 2'd0,
		read_setup = 2'd1,
		read_bus   = 2'd2,
		initialize = 2'd3
	} cache_state_e;

	// Low bits of a stored tag word, so an all-zero line never matches.
	localparam logic [1:0] TAG_VALID = 2'b01;

	// First fetch address after reset.
	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	// One cache line: the word and its full fetch address marked valid.
	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] tag;
	} cache_line_t;

	// A fetched instruction as handed downstream.
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} fetch_t;

	// Tag word for a fetch address.
	function automatic logic [31:0] make_tag(input logic [31:0] pc);
		return {pc[31:2], TAG_VALID};
	endfunction

endpackage

`default_nettype wire
